/* verilog/sram_fifo_pkg.sv */
// shared widths, register map and types of the SRAM-backed readout FIFO
// every block of the core imports this package
package sram_fifo_pkg;

    localparam int unsigned FIFO_DEPTH = 64; // ring size in half-words

    typedef logic [19:0] sram_addr_t; // SRAM address or ring pointer
    typedef logic [15:0] half_t;      // one SRAM half-word
    typedef logic [31:0] word_t;      // source FIFO word
    typedef logic [7:0]  byte_t;      // bus and USB byte
    typedef logic [20:0] fill_t;      // fill level in half-words
    typedef logic [15:0] bus_addr_t;

    // last slot of the ring before the pointers wrap
    localparam sram_addr_t ADDR_LAST = sram_addr_t'(FIFO_DEPTH - 1);

    // near-full thresholds at reset, 95 and 5 percent of 255
    localparam byte_t ALMOST_FULL_DEFAULT  = 8'd242;
    localparam byte_t ALMOST_EMPTY_DEFAULT = 8'd12;

    // register map
    localparam bus_addr_t REG_SOFT_RST  = 16'd0; // write strobe only
    localparam bus_addr_t REG_THR_FULL  = 16'd1; // write
    localparam bus_addr_t REG_THR_EMPTY = 16'd2; // write
    localparam bus_addr_t REG_SIZE_HI   = 16'd1; // read, bits 20..16
    localparam bus_addr_t REG_SIZE_MID  = 16'd2; // read
    localparam bus_addr_t REG_SIZE_LO   = 16'd3; // read
    localparam bus_addr_t REG_RD_ERR    = 16'd4; // read

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_HOLD
    } rd_state_t;

    typedef struct packed {
        logic  empty;
        logic  full;
        fill_t level;        // registered, one cycle behind the pointers
        logic  hold_pending; // captured half-word not yet fully read
    } fifo_status_t;

endpackage

/* verilog/fifo_bus_regs.sv */
// register block of the readout FIFO on the 8-bit bus
// decodes the soft reset, keeps the near-full thresholds and returns
// the fill level and read-error count one cycle after a bus read
`timescale 1ns/1ns

module fifo_bus_regs (
    input  logic                        bus_clk,
    input  logic                        rst,
    input  sram_fifo_pkg::bus_addr_t    bus_add,
    input  sram_fifo_pkg::byte_t        bus_data_in,
    input  logic                        bus_rd,
    input  logic                        bus_wr,
    input  sram_fifo_pkg::fifo_status_t status,
    input  sram_fifo_pkg::byte_t        rd_err_count,
    output logic                        rst_all,
    output sram_fifo_pkg::byte_t        bus_data_out,
    output logic                        near_full,
    output logic                        read_error
);
    import sram_fifo_pkg::*;

    byte_t thr_full;    // almost-full threshold, 255 means the whole ring
    byte_t thr_empty;   // almost-empty threshold
    fill_t size_view;   // level as the bus sees it
    fill_t full_bound;
    fill_t empty_bound;

    // soft reset acts at the next edge like the external reset
    assign rst_all = rst | (bus_wr && bus_add == REG_SOFT_RST);

    always_ff @(posedge bus_clk) begin
        if (rst_all) begin
            thr_full  <= ALMOST_FULL_DEFAULT;
            thr_empty <= ALMOST_EMPTY_DEFAULT;
        end else if (bus_wr) begin
            if (bus_add == REG_THR_FULL)
                thr_full <= bus_data_in;
            if (bus_add == REG_THR_EMPTY)
                thr_empty <= bus_data_in;
        end
    end

    // the half-word sitting in the capture register still counts
    assign size_view = status.level + fill_t'(status.hold_pending);

    // thresholds scale from 1/256 steps to ring slots
    assign full_bound  = fill_t'(((32'(thr_full) + 32'd1) * FIFO_DEPTH) >> 8);
    assign empty_bound = fill_t'(((32'(thr_empty) + 32'd1) * FIFO_DEPTH) >> 8);

    // hysteresis between the two bounds
    always_ff @(posedge bus_clk) begin
        if (rst_all)
            near_full <= 1'b0;
        else if (size_view >= full_bound || thr_full == '0)
            near_full <= 1'b1;
        else if ((size_view <= empty_bound && thr_empty != '0) || size_view == '0)
            near_full <= 1'b0;
    end

    // readback mux
    always_ff @(posedge bus_clk) begin
        if (bus_rd) begin
            case (bus_add)
                REG_SIZE_HI:  bus_data_out <= {3'b000, size_view[20:16]};
                REG_SIZE_MID: bus_data_out <= size_view[15:8];
                REG_SIZE_LO:  bus_data_out <= size_view[7:0];
                REG_RD_ERR:   bus_data_out <= rd_err_count;
                default:      bus_data_out <= '0; // soft reset and unused
            endcase
        end
    end

    assign read_error = (rd_err_count != '0); // sticky until reset

    // a ring drained for two cycles drops near_full unless the bound is zero
    a_near_full_drained: assert property (@(posedge bus_clk) disable iff (rst_all)
        (status.empty && !status.hold_pending) ##1
        (status.empty && !status.hold_pending && full_bound != '0) |=> !near_full);

endmodule

/* verilog/fifo_ring_ptrs.sv */
// ring buffer bookkeeping of the readout FIFO in the external SRAM
// moves the read and write pointers, flags full and empty, registers
// the fill level and splits each source word into two SRAM writes
`timescale 1ns/1ns

module fifo_ring_ptrs (
    input  logic                        bus_clk,
    input  logic                        rst,
    input  logic                        read_sram,
    input  logic                        source_empty,
    input  sram_fifo_pkg::word_t        source_data,
    output logic                        source_pop,
    output logic                        sram_we_b,
    output sram_fifo_pkg::half_t        sram_dout,
    output sram_fifo_pkg::sram_addr_t   sram_wr_addr,
    output sram_fifo_pkg::sram_addr_t   sram_rd_addr,
    output sram_fifo_pkg::fifo_status_t status,
    output logic                        empty
);
    import sram_fifo_pkg::*;

    sram_addr_t rd_ptr;
    sram_addr_t wr_ptr;
    sram_addr_t next_rd_ptr;
    sram_addr_t next_wr_ptr;
    logic       full;
    logic       full_ff;    // full as it will be after this edge
    logic       write_sram;
    logic       wr_adv;
    logic       rd_adv;
    fill_t      level;

    function automatic sram_addr_t ptr_inc(input sram_addr_t ptr);
        return (ptr == ADDR_LAST) ? '0 : ptr + 20'd1;
    endfunction

    // one slot always stays free so that full and empty differ
    function automatic logic ring_full(input sram_addr_t wp, input sram_addr_t rp);
        return ptr_inc(wp) == rp;
    endfunction

    assign next_rd_ptr = ptr_inc(rd_ptr);
    assign next_wr_ptr = ptr_inc(wr_ptr);

    assign empty = (wr_ptr == rd_ptr);
    assign full  = ring_full(wr_ptr, rd_ptr);

    // reads own the SRAM in fetch cycles
    assign write_sram = !source_empty && !full_ff && !read_sram;
    assign wr_adv     = write_sram && !full;
    assign rd_adv     = read_sram && !empty;

    // word is consumed with its low half at the odd address
    assign source_pop = !source_empty && !full && !read_sram && wr_ptr[0];

    // active-low level held for the whole write cycle
    assign sram_we_b = !write_sram;
    assign sram_dout = wr_ptr[0] ? source_data[15:0] : source_data[31:16];

    assign sram_wr_addr = wr_ptr;
    assign sram_rd_addr = rd_ptr;

    always_ff @(posedge bus_clk) begin
        if (rst)
            rd_ptr <= '0;
        else if (rd_adv)
            rd_ptr <= next_rd_ptr;
    end

    always_ff @(posedge bus_clk) begin
        if (rst)
            wr_ptr <= '0;
        else if (wr_adv)
            wr_ptr <= next_wr_ptr;
    end

    // predicted from the pointer values after the edge
    // reads and writes never advance in the same cycle
    always_ff @(posedge bus_clk) begin
        if (rst)
            full_ff <= 1'b0;
        else if (rd_adv)
            full_ff <= ring_full(wr_ptr, next_rd_ptr);
        else if (wr_adv)
            full_ff <= ring_full(next_wr_ptr, rd_ptr);
    end

    always_ff @(posedge bus_clk) begin
        if (rst)
            level <= '0;
        else if (wr_ptr >= rd_ptr)
            level <= fill_t'(wr_ptr - rd_ptr);
        else
            level <= fill_t'(wr_ptr) + fill_t'(FIFO_DEPTH) - fill_t'(rd_ptr);
    end

    // hold_pending comes from the read controller at the top level
    assign status = '{empty: empty, full: full, level: level, hold_pending: 1'b0};

    // registered prediction must agree with the live pointers
    a_no_write_full: assert property (@(posedge bus_clk) disable iff (rst)
        write_sram |-> !full);

    // the read side only fetches from a ring that holds data
    a_no_fetch_empty: assert property (@(posedge bus_clk) disable iff (rst)
        read_sram |-> !empty);

endmodule

/* verilog/fifo_read_ctrl.sv */
// read side of the readout FIFO
// fetches one half-word from the SRAM, presents it as two USB bytes
// (high byte first) and counts USB reads that find nothing to read
`timescale 1ns/1ns

module fifo_read_ctrl (
    input  logic                 bus_clk,
    input  logic                 rst,
    input  logic                 empty,
    input  logic                 usb_read,
    input  sram_fifo_pkg::half_t sram_din,
    output logic                 read_sram,
    output logic                 sram_oe_b,
    output sram_fifo_pkg::byte_t usb_data,
    output logic                 hold_pending,
    output sram_fifo_pkg::byte_t rd_err_count
);
    import sram_fifo_pkg::*;

    rd_state_t state;
    rd_state_t state_next;
    logic      usb_read_dly;
    logic      byte_sel;     // set once the high byte is gone
    half_t     capture;

    always_ff @(posedge bus_clk) begin
        if (rst)
            state <= RD_IDLE;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            RD_IDLE:
                if (!empty)
                    state_next = RD_FETCH;
            RD_FETCH:
                state_next = RD_HOLD;
            RD_HOLD:
                // low byte taken, refill or go wait
                if (usb_read && byte_sel)
                    state_next = empty ? RD_IDLE : RD_FETCH;
            default:
                state_next = RD_IDLE;
        endcase
    end

    assign read_sram    = (state == RD_FETCH);
    assign sram_oe_b    = !read_sram;
    assign hold_pending = (state == RD_HOLD);

    always_ff @(posedge bus_clk) begin
        if (read_sram)
            capture <= sram_din;
    end

    always_ff @(posedge bus_clk) begin
        if (rst)
            usb_read_dly <= 1'b0;
        else
            usb_read_dly <= usb_read;
    end

    // toggles the cycle after the strobe, a fetch starts at the high byte
    always_ff @(posedge bus_clk) begin
        if (rst)
            byte_sel <= 1'b0;
        else if (read_sram)
            byte_sel <= 1'b0;
        else if (usb_read_dly)
            byte_sel <= !byte_sel;
    end

    assign usb_data = byte_sel ? capture[7:0] : capture[15:8];

    // saturating count of reads with nothing stored or held
    always_ff @(posedge bus_clk) begin
        if (rst)
            rd_err_count <= '0;
        else if (usb_read && empty && !hold_pending && rd_err_count != 8'hff)
            rd_err_count <= rd_err_count + 8'd1;
    end

    // byte select lags the strobe by a cycle and needs a gap before the next one
    a_usb_read_gap: assert property (@(posedge bus_clk) disable iff (rst)
        usb_read |=> !usb_read);

endmodule

/* verilog/sram_fifo_core.sv */
// top level of the SRAM-backed readout FIFO
// source words go into the external SRAM ring and come back out as
// USB bytes; the register bus controls thresholds and soft reset
`timescale 1ns/1ns

module sram_fifo_core (
    input  logic                      bus_clk,
    input  logic                      rst,
    input  sram_fifo_pkg::bus_addr_t  bus_add,
    input  sram_fifo_pkg::byte_t      bus_data_in,
    input  logic                      bus_rd,
    input  logic                      bus_wr,
    output sram_fifo_pkg::byte_t      bus_data_out,
    output sram_fifo_pkg::sram_addr_t sram_addr,
    output sram_fifo_pkg::half_t      sram_dout,
    input  sram_fifo_pkg::half_t      sram_din,
    output logic                      sram_we_b,
    output logic                      sram_oe_b,
    input  logic                      usb_read,
    output sram_fifo_pkg::byte_t      usb_data,
    output logic                      source_pop,
    input  logic                      source_empty,
    input  sram_fifo_pkg::word_t      source_data,
    output logic                      not_empty,
    output logic                      full,
    output logic                      near_full,
    output logic                      read_error
);
    import sram_fifo_pkg::*;

    logic         rst_all;
    logic         read_sram;
    logic         empty;
    logic         hold_pending;
    byte_t        rd_err_count;
    sram_addr_t   sram_wr_addr;
    sram_addr_t   sram_rd_addr;
    fifo_status_t ptr_status;
    fifo_status_t reg_status;

    fifo_ring_ptrs u_ptrs (
        .bus_clk      (bus_clk),
        .rst          (rst_all),
        .read_sram    (read_sram),
        .source_empty (source_empty),
        .source_data  (source_data),
        .source_pop   (source_pop),
        .sram_we_b    (sram_we_b),
        .sram_dout    (sram_dout),
        .sram_wr_addr (sram_wr_addr),
        .sram_rd_addr (sram_rd_addr),
        .status       (ptr_status),
        .empty        (empty)
    );

    fifo_read_ctrl u_rd (
        .bus_clk      (bus_clk),
        .rst          (rst_all),
        .empty        (empty),
        .usb_read     (usb_read),
        .sram_din     (sram_din),
        .read_sram    (read_sram),
        .sram_oe_b    (sram_oe_b),
        .usb_data     (usb_data),
        .hold_pending (hold_pending),
        .rd_err_count (rd_err_count)
    );

    // pointer status plus the held half-word from the read side
    always_comb begin
        reg_status = ptr_status;
        reg_status.hold_pending = hold_pending;
    end

    fifo_bus_regs u_regs (
        .bus_clk      (bus_clk),
        .rst          (rst),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .status       (reg_status),
        .rd_err_count (rd_err_count),
        .rst_all      (rst_all),
        .bus_data_out (bus_data_out),
        .near_full    (near_full),
        .read_error   (read_error)
    );

    assign sram_addr = read_sram ? sram_rd_addr : sram_wr_addr;

    assign not_empty = !empty || hold_pending; // stored or still held
    assign full      = ptr_status.full;

endmodule

/* bench/sram_fifo_checker.sv */
// watcher of the readout FIFO core for the testbench
// builds the expected byte stream, fill level and error count from the
// source pops and USB strobes, then compares bytes, bus reads and flags
`timescale 1ns/1ns

module sram_fifo_checker (
    input  logic                     BUS_CLK,
    input  logic                     RST,
    input  sram_fifo_pkg::bus_addr_t bus_add,
    input  logic                     bus_rd,
    input  logic                     bus_wr,
    input  sram_fifo_pkg::byte_t     bus_data_out,
    input  logic                     usb_read,
    input  sram_fifo_pkg::byte_t     usb_data,
    input  logic                     sram_oe_b,
    input  logic                     source_pop,
    input  sram_fifo_pkg::word_t     source_data,
    input  logic                     full,
    input  logic                     near_full,
    input  logic                     read_error,
    input  logic                     not_empty,
    input  logic                     flag_req,
    input  logic [3:0]               flag_exp,  // full, near_full, read_error, not_empty
    input  logic                     test_end,
    input  logic [7:0]               test_num,
    input  logic                     all_done,
    output logic [1:0]               byte_avail,
    output int                       error_count
);
    import sram_fifo_pkg::*;

    byte_t ref_q [$];         // bytes still owed on usb_data
    int    halves_in = 0;
    int    halves_out = 0;
    int    err_ref = 0;
    logic  low_next = 1'b0;   // next byte is the low one of its half-word
    logic  rd_pending = 1'b0;
    byte_t rd_expect;
    int    checks = 0;
    int    errors = 0;
    int    test_checks = 0;
    int    test_errors = 0;
    int    tests = 0;

    assign error_count = errors;

    // register map as seen from the bus
    function automatic byte_t expected_reg(input bus_addr_t a);
        fill_t s;
        s = fill_t'(halves_in - halves_out);
        case (a)
            16'd1:   return {3'b000, s[20:16]};
            16'd2:   return s[15:8];
            16'd3:   return s[7:0];
            16'd4:   return byte_t'(err_ref);
            default: return 8'h00;
        endcase
    endfunction

    task automatic compare(input string name, input byte_t exp, input byte_t got);
        checks++;
        test_checks++;
        if (exp !== got) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic problem(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    always @(posedge BUS_CLK) begin
        if (rd_pending)
            compare("bus_data_out", rd_expect, bus_data_out);
        rd_pending = bus_rd;
        rd_expect  = expected_reg(bus_add);

        if (RST || (bus_wr && bus_add == 16'd0)) begin
            ref_q.delete();
            halves_in  = 0;
            halves_out = 0;
            err_ref    = 0;
            low_next   = 1'b0;
            byte_avail = 2'd0;
        end else begin
            if (source_pop) begin
                ref_q.push_back(source_data[31:24]); // most significant first
                ref_q.push_back(source_data[23:16]);
                ref_q.push_back(source_data[15:8]);
                ref_q.push_back(source_data[7:0]);
                halves_in += 2;
            end
            if (source_pop && full)
                problem("source word popped while the FIFO was full");
            if (!sram_oe_b) begin
                byte_avail = 2'd2; // capture lands at this edge
            end else if (usb_read && byte_avail == 2'd0) begin
                if (err_ref < 255)
                    err_ref++;
            end else if (usb_read) begin
                byte_avail = byte_avail - 2'd1;
                if (ref_q.size() == 0)
                    problem("USB byte read with no data left to expect");
                else
                    compare("usb_data", ref_q.pop_front(), usb_data);
                if (low_next)
                    halves_out++;
                low_next = !low_next;
            end
        end

        if (flag_req) begin
            compare("full", {7'b0, flag_exp[3]}, {7'b0, full});
            compare("near_full", {7'b0, flag_exp[2]}, {7'b0, near_full});
            compare("read_error", {7'b0, flag_exp[1]}, {7'b0, read_error});
            compare("not_empty", {7'b0, flag_exp[0]}, {7'b0, not_empty});
        end
        if (test_end) begin
            $display("test %0d: %0d checks, %0d errors", test_num, test_checks, test_errors);
            tests++;
            test_checks = 0;
            test_errors = 0;
        end
        if (all_done)
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    end

endmodule

/* bench/tb_sram_fifo.sv */
// testbench top for the SRAM-backed readout FIFO
// runs the command lines of the pattern file against the core, with a
// behavioral SRAM and a word queue standing in for the source FIFO
`timescale 1ns/1ns

module tb_sram_fifo;
    import sram_fifo_pkg::*;

    localparam int MAX_LINES  = 64;
    localparam int LINE_LIMIT = 40; // cycles allowed per pattern line

    logic        BUS_CLK = 1'b0;
    logic        RST;
    bus_addr_t   bus_add;
    byte_t       bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    byte_t       bus_data_out;
    sram_addr_t  sram_addr;
    half_t       sram_dout;
    half_t       sram_din;
    logic        sram_we_b;
    logic        sram_oe_b;
    logic        usb_read;
    byte_t       usb_data;
    logic        source_pop;
    logic        source_empty;
    word_t       source_data;
    logic        not_empty;
    logic        full;
    logic        near_full;
    logic        read_error;
    logic [1:0]  byte_avail;  // bytes ready on usb_data, from the checker
    logic        flag_req;
    logic [3:0]  flag_exp;
    logic        test_end;
    logic [7:0]  test_num;
    logic        all_done;
    int          error_count;

    logic [47:0] patterns [MAX_LINES];
    half_t       sram_mem [FIFO_DEPTH];
    word_t       src_q [$];
    int          n_lines;
    int          bad_lines = 0;
    int          cycle_limit = 0;
    int          cycles = 0;

    always #4 BUS_CLK = ~BUS_CLK;

    sram_fifo_core dut (
        .bus_clk(BUS_CLK), .rst(RST), .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_rd(bus_rd), .bus_wr(bus_wr), .bus_data_out(bus_data_out),
        .sram_addr(sram_addr), .sram_dout(sram_dout), .sram_din(sram_din),
        .sram_we_b(sram_we_b), .sram_oe_b(sram_oe_b), .usb_read(usb_read),
        .usb_data(usb_data), .source_pop(source_pop), .source_empty(source_empty),
        .source_data(source_data), .not_empty(not_empty), .full(full),
        .near_full(near_full), .read_error(read_error)
    );

    sram_fifo_checker chk (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus_add(bus_add), .bus_rd(bus_rd),
        .bus_wr(bus_wr), .bus_data_out(bus_data_out), .usb_read(usb_read),
        .usb_data(usb_data), .sram_oe_b(sram_oe_b), .source_pop(source_pop),
        .source_data(source_data), .full(full), .near_full(near_full),
        .read_error(read_error), .not_empty(not_empty), .flag_req(flag_req),
        .flag_exp(flag_exp), .test_end(test_end), .test_num(test_num),
        .all_done(all_done), .byte_avail(byte_avail), .error_count(error_count)
    );

    // asynchronous SRAM, write on the edge while we_b is low
    always @(posedge BUS_CLK) begin
        if (!sram_we_b)
            sram_mem[sram_addr[5:0]] <= sram_dout;
    end
    assign sram_din = sram_oe_b ? 16'h0000 : sram_mem[sram_addr[5:0]];

    always @(posedge BUS_CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run stopped, no progress within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic refresh_source();
        source_empty = (src_q.size() == 0);
        source_data  = (src_q.size() > 0) ? src_q[0] : '0;
    endtask

    // one clock, pops the source word if the DUT took it at the edge
    task automatic step();
        logic popped;
        @(posedge BUS_CLK);
        popped = source_pop;
        @(negedge BUS_CLK);
        if (popped && src_q.size() > 0)
            void'(src_q.pop_front());
        refresh_source();
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 3) begin
            step();
            if (sram_we_b && sram_oe_b)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    task automatic push_words(input int count, input word_t first);
        for (int i = 0; i < count; i++)
            src_q.push_back(first + word_t'(i) * 32'h0403_0201);
        refresh_source();
    endtask

    task automatic read_bytes(input int count);
        for (int i = 0; i < count; i++) begin
            while (byte_avail == 2'd0)
                step();
            usb_read = 1'b1;
            step();
            usb_read = 1'b0;
            step(); // byte select moves one cycle after the strobe
        end
    endtask

    task automatic pulse_usb_read();
        usb_read = 1'b1;
        step();
        usb_read = 1'b0;
        step();
    endtask

    task automatic bus_write(input bus_addr_t addr, input byte_t value);
        bus_add     = addr;
        bus_data_in = value;
        bus_wr      = 1'b1;
        step();
        bus_wr = 1'b0;
        step();
    endtask

    task automatic bus_read(input bus_addr_t addr);
        bus_add = addr;
        bus_rd  = 1'b1;
        step();
        bus_rd = 1'b0;
        step(); // data compared at the following edge
    endtask

    task automatic run_line(input logic [47:0] line);
        logic [7:0] cmd;
        logic [7:0] arg;
        word_t      data;
        cmd  = line[47:40];
        arg  = line[39:32];
        data = line[31:0];
        case (cmd)
            8'h01: push_words(int'(arg), data);
            8'h02: read_bytes(int'(arg));
            8'h03: pulse_usb_read();
            8'h04: bus_write(bus_addr_t'(arg), data[7:0]);
            8'h05: begin
                wait_idle();
                bus_read(bus_addr_t'(arg));
            end
            8'h07: begin
                wait_idle();
                flag_exp = data[3:0];
                flag_req = 1'b1;
                step();
                flag_req = 1'b0;
            end
            8'h08: begin
                wait_idle();
                bus_read(REG_SIZE_HI);
                bus_read(REG_SIZE_MID);
                bus_read(REG_SIZE_LO);
            end
            8'h0f: begin
                test_num = arg;
                test_end = 1'b1;
                step();
                test_end = 1'b0;
            end
            default: begin
                $display("pattern line with unknown command %h", cmd);
                bad_lines++;
            end
        endcase
    endtask

    initial begin
        RST          = 1'b1;
        bus_add      = '0;
        bus_data_in  = '0;
        bus_rd       = 1'b0;
        bus_wr       = 1'b0;
        usb_read     = 1'b0;
        source_empty = 1'b1;
        source_data  = '0;
        flag_req     = 1'b0;
        flag_exp     = '0;
        test_end     = 1'b0;
        test_num     = '0;
        all_done     = 1'b0;
        for (int i = 0; i < MAX_LINES; i++)
            patterns[i] = '0;
        $readmemh("bench/sram_fifo_patterns.txt", patterns);
        n_lines = 0;
        while (n_lines < MAX_LINES && patterns[n_lines][47:40] != 8'h00)
            n_lines++;
        cycle_limit = (n_lines + 1) * LINE_LIMIT; // reset and wrap-up included
        if (n_lines == 0)
            $display("pattern file gave no command lines");
        repeat (10) step();
        RST = 1'b0;
        for (int i = 0; i < n_lines; i++)
            run_line(patterns[i]);
        all_done = 1'b1;
        step();
        all_done = 1'b0;
        if (error_count == 0 && bad_lines == 0 && n_lines > 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* bench/sram_fifo_patterns.txt */
// one hex word per line, cmd_arg_data; 01 push arg words from data, 02 read arg USB bytes
// 03 USB read while empty, 04 bus write data to arg, 05 bus read arg, 07 flags data
// {full,near_full,read_error,not_empty}, 08 size registers, 0f end of test arg
01_03_a1b2c3d4 // test 1, byte order
02_0c_00000000
07_00_00000000
0f_01_00000000
01_28_10000000 // test 2, 40 words against a full ring
07_00_0000000d
02_a0_00000000
07_00_00000000
0f_02_00000000
01_04_11223344 // test 3, size registers
08_00_00000000
02_06_00000000
08_00_00000000
02_0a_00000000
08_00_00000000
0f_03_00000000
03_00_00000000 // test 4, read while empty and soft reset
05_04_00000000
07_00_00000002
01_02_5a5a0001
08_00_00000000
04_00_00000000
05_04_00000000
08_00_00000000
07_00_00000000
0f_04_00000000
04_01_0000007f // test 5, near_full hysteresis
01_0f_30000000
07_00_00000001
01_01_3f000000
07_00_00000005
02_38_00000000
07_00_00000005
02_02_00000000
07_00_00000001
02_06_00000000
07_00_00000000
08_00_00000000
0f_05_00000000

/* vlog.f */
verilog/sram_fifo_pkg.sv
verilog/fifo_bus_regs.sv
verilog/fifo_ring_ptrs.sv
verilog/fifo_read_ctrl.sv
verilog/sram_fifo_core.sv
bench/sram_fifo_checker.sv
bench/tb_sram_fifo.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -j 0 -f vlog.f --top-module tb_sram_fifo -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
